// ==== bench/shift_model.svh ====
`ifndef SHIFT_MODEL_SVH
`define SHIFT_MODEL_SVH

// increment for v shifted right by d, lsb is the shifted result's bit 0
function automatic logic round_incr(logic [31:0] v, int d, logic lsb,
                                    vx_shift_pkg::vxrm_e rm);
  logic r_top;
  logic r_low;
  r_top = 1'b0;
  r_low = 1'b0;
  if (d > 0) begin
    r_top = v[d-1];
  end
  if (d > 1) begin
    r_low = (v & ((32'd1 << (d - 1)) - 32'd1)) != 32'd0;
  end
  case (rm)
    vx_shift_pkg::RNU: return r_top;
    vx_shift_pkg::RNE: return r_top & (r_low | lsb);
    vx_shift_pkg::RDN: return 1'b0;
    default:           return ~lsb & (r_top | r_low);
  endcase
endfunction

// right shift of a sew-bit element, full precision, optional rounding
function automatic longint scaled_elem(logic [31:0] v, int sew, int d, logic arith,
                                       logic rnd, vx_shift_pkg::vxrm_e rm);
  longint x;
  longint s;
  x = longint'({32'd0, v});
  if (arith && v[sew-1]) begin
    x = x - (64'sd1 <<< sew);
  end
  s = x >>> d;
  if (rnd) begin
    s = s + longint'({63'd0, round_incr(v, d, s[0], rm)});
  end
  return s;
endfunction

function automatic vx_shift_pkg::shift_result_t expected_result(vx_shift_pkg::shift_uop_t u);
  vx_shift_pkg::shift_result_t r;
  logic [vx_shift_pkg::VLEN-1:0] narrowed;
  logic [vx_shift_pkg::VLEN-1:0] mask;
  logic [31:0]                   v;
  longint                        s;
  longint                        hi;
  longint                        lo;
  int                            sew;
  int                            hw;
  int                            d;
  logic                          narrow;
  logic                          arith;
  logic                          rnd;
  r        = '0;
  narrowed = '0;
  sew      = (u.eew == vx_shift_pkg::EEW8) ? 8 : ((u.eew == vx_shift_pkg::EEW16) ? 16 : 32);
  hw       = sew / 2;
  mask     = (64'd1 << sew) - 64'd1;
  narrow   = (u.funct6 == vx_shift_pkg::VNCLIPU) || (u.funct6 == vx_shift_pkg::VNCLIP);
  arith    = (u.funct6 == vx_shift_pkg::VSRA) || (u.funct6 == vx_shift_pkg::VSSRA) ||
             (u.funct6 == vx_shift_pkg::VNCLIP);
  rnd      = narrow || (u.funct6 == vx_shift_pkg::VSSRL) || (u.funct6 == vx_shift_pkg::VSSRA);
  for (int e = 0; e < vx_shift_pkg::VLEN / sew; e++) begin
    v = 32'((u.vs2 >> (e * sew)) & mask);
    if (u.funct3 == vx_shift_pkg::OPIVV) begin
      d = int'(32'(u.vs1 >> (e * sew))) & (sew - 1);
    end else begin
      d = int'(u.rs1) & (sew - 1);
    end
    if (u.funct6 == vx_shift_pkg::VSLL) begin
      s = longint'((64'(v) << d) & mask);
    end else begin
      s = scaled_elem(v, sew, d, arith, rnd, u.vxrm);
    end
    if (!narrow) begin
      r.data = r.data | ((64'(s) & mask) << (e * sew));
    end else begin
      hi = arith ? (64'sd1 <<< (hw - 1)) - 64'sd1 : (64'sd1 <<< hw) - 64'sd1;
      lo = arith ? -(64'sd1 <<< (hw - 1)) : 64'sd0;
      if (s > hi) begin
        s       = hi;
        r.vxsat = 1'b1;
      end else if (s < lo) begin
        s       = lo;
        r.vxsat = 1'b1;
      end
      narrowed = narrowed | ((64'(s) & ((64'd1 << hw) - 64'd1)) << (e * hw));
    end
  end
  if (narrow) begin
    r.data = u.uop_index ? (narrowed << 32) : narrowed;
  end
  return r;
endfunction

`endif

// ==== bench/vx_shift_unit_tb.sv ====
`timescale 1ns/1ps

module vx_shift_unit_tb;

  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_COUNT = 300;
  localparam int DRAIN_CYCLES = 6;
  localparam int LATENCY      = 3;

  typedef struct packed {
    logic                          drive;
    vx_shift_pkg::shift_uop_t      uop;
    logic                          expect_valid;
    vx_shift_pkg::shift_result_t   expected;
  } entry_t;

  logic                        clk;
  logic                        rst;
  logic                        in_valid;
  vx_shift_pkg::shift_uop_t    uop;
  logic                        result_valid;
  vx_shift_pkg::shift_result_t result;

  entry_t table_q[$];
  entry_t pending_q[$];
  logic   table_ready;

  `include "shift_model.svh"

  vx_shift_unit dut (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .uop          (uop),
    .result_valid (result_valid),
    .result       (result)
  );

  always #50 clk = ~clk;

  task automatic stop_with_error(string what);
    $display("Fail at %0t ns: %s", $time, what);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic add_entry(logic drive, vx_shift_pkg::shift_uop_t u, logic ev,
                           logic [vx_shift_pkg::VLEN-1:0] data, logic sat);
    entry_t e;
    e.drive          = drive;
    e.uop            = u;
    e.expect_valid   = ev;
    e.expected.data  = data;
    e.expected.vxsat = sat;
    table_q.push_back(e);
  endtask

  task automatic add_op(vx_shift_pkg::shift_funct6_e f6, vx_shift_pkg::operand_src_e f3,
                        vx_shift_pkg::eew_e eew, vx_shift_pkg::vxrm_e rm,
                        logic [63:0] vs1, logic [63:0] vs2, logic [31:0] rs1, logic idx,
                        logic ev, logic [63:0] data, logic sat);
    vx_shift_pkg::shift_uop_t u;
    u.funct6    = f6;
    u.funct3    = f3;
    u.eew       = eew;
    u.vxrm      = rm;
    u.vs1       = vs1;
    u.vs2       = vs2;
    u.rs1       = rs1;
    u.uop_index = idx;
    add_entry(1'b1, u, ev, data, sat);
  endtask

  function automatic vx_shift_pkg::shift_funct6_e pick_funct6(int unsigned r);
    case (r)
      0:       return vx_shift_pkg::VSLL;
      1:       return vx_shift_pkg::VSRL;
      2:       return vx_shift_pkg::VSRA;
      3:       return vx_shift_pkg::VSSRL;
      4:       return vx_shift_pkg::VSSRA;
      5:       return vx_shift_pkg::VNCLIPU;
      6:       return vx_shift_pkg::VNCLIP;
      default: return vx_shift_pkg::shift_funct6_e'(6'h07);
    endcase
  endfunction

  function automatic logic is_supported(vx_shift_pkg::shift_uop_t u);
    case (u.funct6)
      vx_shift_pkg::VSLL, vx_shift_pkg::VSRL, vx_shift_pkg::VSRA,
      vx_shift_pkg::VSSRL, vx_shift_pkg::VSSRA: return 1'b1;
      vx_shift_pkg::VNCLIPU, vx_shift_pkg::VNCLIP: return u.eew != vx_shift_pkg::EEW8;
      default: return 1'b0;
    endcase
  endfunction

  task automatic build_fixed_table();
    vx_shift_pkg::shift_uop_t idle;
    idle        = '0;
    idle.funct6 = vx_shift_pkg::VSLL;
    // single width with the amount masked to log2(sew) bits
    add_op(vx_shift_pkg::VSLL, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW8, vx_shift_pkg::RNU,
           64'h0, 64'h0102_0408_1020_4080, 32'd9, 1'b0, 1'b1, 64'h0204_0810_2040_8000, 1'b0);
    add_op(vx_shift_pkg::VSRL, vx_shift_pkg::OPIVI, vx_shift_pkg::EEW16, vx_shift_pkg::RNU,
           64'h0, 64'h8000_F00F_1234_0001, 32'd20, 1'b0, 1'b1, 64'h0800_0F00_0123_0000, 1'b0);
    add_op(vx_shift_pkg::VSRA, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW32, vx_shift_pkg::RNU,
           64'h0, 64'h8000_0000_7FFF_FFF0, 32'd36, 1'b0, 1'b1, 64'hF800_0000_07FF_FFFF, 1'b0);
    add_op(vx_shift_pkg::VSRA, vx_shift_pkg::OPIVV, vx_shift_pkg::EEW8, vx_shift_pkg::RNU,
           64'h0001_070F_0001_0708, 64'h8080_8080_7F7F_7F7F, 32'd0, 1'b0, 1'b1,
           64'h80C0_FFFF_7F3F_007F, 1'b0);
    add_op(vx_shift_pkg::VSLL, vx_shift_pkg::OPIVV, vx_shift_pkg::EEW16, vx_shift_pkg::RNU,
           64'h000F_0010_0003_0008, 64'h0001_0001_0001_0001, 32'd0, 1'b0, 1'b1,
           64'h8000_0001_0008_0100, 1'b0);
    // scaling shifts with one row per rounding mode
    add_op(vx_shift_pkg::VSSRL, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW8, vx_shift_pkg::RNU,
           64'h0, 64'h0506_070A_0E04_FFFE, 32'd2, 1'b0, 1'b1, 64'h0102_0203_0401_4040, 1'b0);
    add_op(vx_shift_pkg::VSSRL, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW8, vx_shift_pkg::RNE,
           64'h0, 64'h0506_070A_0E04_FFFE, 32'd2, 1'b0, 1'b1, 64'h0102_0202_0401_4040, 1'b0);
    add_op(vx_shift_pkg::VSSRL, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW8, vx_shift_pkg::RDN,
           64'h0, 64'h0506_070A_0E04_FFFE, 32'd2, 1'b0, 1'b1, 64'h0101_0102_0301_3F3F, 1'b0);
    add_op(vx_shift_pkg::VSSRL, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW8, vx_shift_pkg::ROD,
           64'h0, 64'h0506_070A_0E04_FFFE, 32'd2, 1'b0, 1'b1, 64'h0101_0103_0301_3F3F, 1'b0);
    // -8 >> 4 rounds up through zero
    add_op(vx_shift_pkg::VSSRA, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW16, vx_shift_pkg::RNU,
           64'h0, 64'hFFF8_0028_8000_7FFF, 32'd4, 1'b0, 1'b1, 64'h0000_0003_F800_0800, 1'b0);
    add_op(vx_shift_pkg::VSSRA, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW16, vx_shift_pkg::RNE,
           64'h0, 64'hFFF8_0028_8000_7FFF, 32'd4, 1'b0, 1'b1, 64'h0000_0002_F800_0800, 1'b0);
    add_op(vx_shift_pkg::VSSRA, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW16, vx_shift_pkg::RDN,
           64'h0, 64'hFFF8_0028_8000_7FFF, 32'd4, 1'b0, 1'b1, 64'hFFFF_0002_F800_07FF, 1'b0);
    add_op(vx_shift_pkg::VSSRA, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW16, vx_shift_pkg::ROD,
           64'h0, 64'hFFF8_0028_8000_7FFF, 32'd4, 1'b0, 1'b1, 64'hFFFF_0003_F800_07FF, 1'b0);
    add_op(vx_shift_pkg::VSSRA, vx_shift_pkg::OPIVV, vx_shift_pkg::EEW32, vx_shift_pkg::RNU,
           64'h0000_001F_0000_0001, 64'h8000_0001_0000_0003, 32'd0, 1'b0, 1'b1,
           64'hFFFF_FFFF_0000_0002, 1'b0);
    // narrowing clips
    add_op(vx_shift_pkg::VNCLIPU, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW16, vx_shift_pkg::RDN,
           64'h0, 64'h0FF0_1000_0120_0000, 32'd4, 1'b0, 1'b1, 64'h0000_0000_FFFF_1200, 1'b1);
    add_op(vx_shift_pkg::VNCLIPU, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW16, vx_shift_pkg::RDN,
           64'h0, 64'h0FF0_0340_0120_0010, 32'd4, 1'b1, 1'b1, 64'hFF34_1201_0000_0000, 1'b0);
    add_op(vx_shift_pkg::VNCLIP, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW16, vx_shift_pkg::RNU,
           64'h0, 64'h00FE_00FF_FF00_FEFF, 32'd1, 1'b0, 1'b1, 64'h0000_0000_7F7F_8080, 1'b1);
    add_op(vx_shift_pkg::VNCLIP, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW32, vx_shift_pkg::RDN,
           64'h0, 64'hFFFF_7FFF_0000_8000, 32'd0, 1'b1, 1'b1, 64'h8000_7FFF_0000_0000, 1'b1);
    // rounding pushes the value past the narrow range
    add_op(vx_shift_pkg::VNCLIPU, vx_shift_pkg::OPIVV, vx_shift_pkg::EEW32, vx_shift_pkg::RNE,
           64'h0000_0001_0000_0004, 64'h0001_FFFF_0000_0FFF, 32'd0, 1'b0, 1'b1,
           64'h0000_0000_FFFF_0100, 1'b1);
    add_op(vx_shift_pkg::VNCLIP, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW32, vx_shift_pkg::RNU,
           64'h0, 64'h0000_1234_FFFF_8000, 32'd0, 1'b0, 1'b1, 64'h0000_0000_1234_8000, 1'b0);
    // rejected inputs and an idle slot
    add_op(vx_shift_pkg::VNCLIPU, vx_shift_pkg::OPIVX, vx_shift_pkg::EEW8, vx_shift_pkg::RNU,
           64'h0, 64'hFFFF_FFFF_FFFF_FFFF, 32'd1, 1'b0, 1'b0, 64'h0, 1'b0);
    add_op(vx_shift_pkg::VNCLIP, vx_shift_pkg::OPIVV, vx_shift_pkg::EEW8, vx_shift_pkg::RNE,
           64'h0, 64'h1234_5678_9ABC_DEF0, 32'd0, 1'b1, 1'b0, 64'h0, 1'b0);
    add_op(vx_shift_pkg::shift_funct6_e'(6'h00), vx_shift_pkg::OPIVX, vx_shift_pkg::EEW16,
           vx_shift_pkg::RNU, 64'h0, 64'h1111_2222_3333_4444, 32'd3, 1'b0, 1'b0, 64'h0, 1'b0);
    add_entry(1'b0, idle, 1'b0, 64'h0, 1'b0);
  endtask

  task automatic build_random_table();
    vx_shift_pkg::shift_uop_t    u;
    vx_shift_pkg::shift_result_t r;
    logic                        drive;
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      u.funct6 = pick_funct6($urandom_range(0, 7));
      case ($urandom_range(0, 2))
        0:       u.funct3 = vx_shift_pkg::OPIVV;
        1:       u.funct3 = vx_shift_pkg::OPIVX;
        default: u.funct3 = vx_shift_pkg::OPIVI;
      endcase
      u.eew       = vx_shift_pkg::eew_e'(2'($urandom_range(0, 2)));
      u.vxrm      = vx_shift_pkg::vxrm_e'(2'($urandom));
      u.vs1       = {$urandom, $urandom};
      u.vs2       = {$urandom, $urandom};
      u.rs1       = $urandom;
      u.uop_index = 1'($urandom);
      drive       = ($urandom_range(0, 7) != 0);
      r           = expected_result(u);
      add_entry(drive, u, drive && is_supported(u), r.data, r.vxsat);
    end
  endtask

  task automatic check_output(entry_t due);
    assert (result_valid === due.expect_valid) else
      stop_with_error($sformatf("result_valid %b, expected %b (funct6 %h)",
                                result_valid, due.expect_valid, due.uop.funct6));
    if (due.expect_valid) begin
      assert (result.data === due.expected.data) else
        stop_with_error($sformatf("data %h, expected %h (funct6 %h eew %0d)",
                                  result.data, due.expected.data, due.uop.funct6,
                                  due.uop.eew));
      assert (result.vxsat === due.expected.vxsat) else
        stop_with_error($sformatf("vxsat %b, expected %b (funct6 %h)",
                                  result.vxsat, due.expected.vxsat, due.uop.funct6));
    end
  endtask

  initial begin
    entry_t e;
    entry_t due;
    clk         = 1'b0;
    rst         = 1'b1;
    in_valid    = 1'b0;
    uop         = '0;
    table_ready = 1'b0;
    void'($urandom(32'h6779));
    build_fixed_table();
    build_random_table();
    table_ready = 1'b1;
    // accepted micro-ops offered during reset must not come out
    in_valid    = 1'b1;
    uop         = table_q[0].uop;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      assert (result_valid === 1'b0) else
        stop_with_error("result_valid not low during reset");
    end
    rst = 1'b0;
    // outputs settle before the falling edge so check first and then drive
    for (int i = 0; i < table_q.size() + DRAIN_CYCLES; i++) begin
      if (pending_q.size() == LATENCY) begin
        due = pending_q.pop_front();
        check_output(due);
      end
      if (i < table_q.size()) begin
        e = table_q[i];
      end else begin
        e = '0;
      end
      in_valid = e.drive;
      uop      = e.uop;
      pending_q.push_back(e);
      @(negedge clk);
    end
    $display("Test completed successfully");
    $finish;
  end

  // watchdog
  initial begin
    wait (table_ready);
    #((table_q.size() + 40) * 100);
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== rtl/narrow_clip_stage.sv ====
`timescale 1ns/1ps

module narrow_clip_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       lane_valid,
  input  vx_shift_pkg::lane_bundle_t lanes,
  output logic                       result_valid,
  output vx_shift_pkg::shift_result_t result
);

  logic [vx_shift_pkg::VLEN/2-1:0]    narrowed;
  logic [vx_shift_pkg::HWORD_WIDTH:0] clip;
  logic                               clip_signed;
  logic                               sat_any;
  vx_shift_pkg::shift_result_t        result_next;

  // returns {saturated, narrowed value}; only the low hw bits of the value count
  function automatic logic [vx_shift_pkg::HWORD_WIDTH:0] clip_elem(
    input logic [vx_shift_pkg::WORD_WIDTH:0] val,
    input int unsigned                       hw,
    input logic                              is_signed
  );
    logic [vx_shift_pkg::WORD_WIDTH:0] umax;
    logic [vx_shift_pkg::WORD_WIDTH:0] smax;
    logic [vx_shift_pkg::WORD_WIDTH:0] smin;
    logic [vx_shift_pkg::WORD_WIDTH:0] res;
    logic                              sat;
    umax     = '0;
    umax[hw] = 1'b1;
    umax     = umax - {{vx_shift_pkg::WORD_WIDTH{1'b0}}, 1'b1};
    smax     = umax >> 1;
    smin     = ~smax;
    res      = val;
    sat      = 1'b0;
    if (is_signed) begin
      if ($signed(val) > $signed(smax)) begin
        res = smax;
        sat = 1'b1;
      end else if ($signed(val) < $signed(smin)) begin
        res = smin;
        sat = 1'b1;
      end
    end else if (val > umax) begin
      res = umax;
      sat = 1'b1;
    end
    return {sat, res[vx_shift_pkg::HWORD_WIDTH-1:0]};
  endfunction

  always_comb begin
    narrowed    = '0;
    clip        = '0;
    sat_any     = 1'b0;
    result_next = '0;
    clip_signed = (lanes.ctx.funct6 == vx_shift_pkg::VNCLIP);
    case (lanes.ctx.funct6)
      vx_shift_pkg::VSLL,
      vx_shift_pkg::VSRL,
      vx_shift_pkg::VSRA: begin
        case (lanes.ctx.eew)
          vx_shift_pkg::EEW8:  result_next.data = lanes.shifted8;
          vx_shift_pkg::EEW16: result_next.data = lanes.shifted16;
          vx_shift_pkg::EEW32: result_next.data = lanes.shifted32;
          default:             result_next.data = '0;
        endcase
      end
      vx_shift_pkg::VSSRL,
      vx_shift_pkg::VSSRA: begin
        case (lanes.ctx.eew)
          vx_shift_pkg::EEW8:  result_next.data = lanes.rounded8;
          vx_shift_pkg::EEW16: result_next.data = lanes.rounded16;
          vx_shift_pkg::EEW32: result_next.data = lanes.rounded32;
          default:             result_next.data = '0;
        endcase
      end
      vx_shift_pkg::VNCLIPU,
      vx_shift_pkg::VNCLIP: begin
        if (lanes.ctx.eew == vx_shift_pkg::EEW16) begin
          for (int i = 0; i < vx_shift_pkg::NUM_HWORDS; i++) begin
            // 17-bit sum widened to 33 bits
            clip = clip_elem({{vx_shift_pkg::HWORD_WIDTH{clip_signed & lanes.cout16[i]}},
                              lanes.cout16[i], lanes.rounded16[i]},
                             vx_shift_pkg::BYTE_WIDTH, clip_signed);
            narrowed[i*vx_shift_pkg::BYTE_WIDTH +: vx_shift_pkg::BYTE_WIDTH] =
              clip[vx_shift_pkg::BYTE_WIDTH-1:0];
            sat_any = sat_any | clip[vx_shift_pkg::HWORD_WIDTH];
          end
        end else if (lanes.ctx.eew == vx_shift_pkg::EEW32) begin
          for (int i = 0; i < vx_shift_pkg::NUM_WORDS; i++) begin
            clip = clip_elem({lanes.cout32[i], lanes.rounded32[i]},
                             vx_shift_pkg::HWORD_WIDTH, clip_signed);
            narrowed[i*vx_shift_pkg::HWORD_WIDTH +: vx_shift_pkg::HWORD_WIDTH] =
              clip[vx_shift_pkg::HWORD_WIDTH-1:0];
            sat_any = sat_any | clip[vx_shift_pkg::HWORD_WIDTH];
          end
        end
        // other half stays zero
        if (lanes.ctx.uop_index) begin
          result_next.data[vx_shift_pkg::VLEN/2 +: vx_shift_pkg::VLEN/2] = narrowed;
        end else begin
          result_next.data[0 +: vx_shift_pkg::VLEN/2] = narrowed;
        end
        result_next.vxsat = sat_any;
      end
      default: begin
        result_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= lane_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (lane_valid) begin
      result <= result_next;
    end
  end

endmodule

// ==== rtl/shift_operand_stage.sv ====
`timescale 1ns/1ps

module shift_operand_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  vx_shift_pkg::shift_uop_t      uop,
  output logic                          op_valid,
  output vx_shift_pkg::operand_bundle_t ops
);

  vx_shift_pkg::shift_op_e          op;
  logic                             known;
  logic                             narrow;
  logic                             accept;
  logic [vx_shift_pkg::SHAMT_WIDTH-1:0] raw_amount;
  vx_shift_pkg::operand_bundle_t    ops_next;

  // funct6 decode
  always_comb begin
    known  = 1'b1;
    narrow = 1'b0;
    op     = vx_shift_pkg::SHIFT_SLL;
    case (uop.funct6)
      vx_shift_pkg::VSLL: begin
        op = vx_shift_pkg::SHIFT_SLL;
      end
      vx_shift_pkg::VSRL,
      vx_shift_pkg::VSSRL: begin
        op = vx_shift_pkg::SHIFT_SRL;
      end
      vx_shift_pkg::VSRA,
      vx_shift_pkg::VSSRA: begin
        op = vx_shift_pkg::SHIFT_SRA;
      end
      vx_shift_pkg::VNCLIPU: begin
        op     = vx_shift_pkg::SHIFT_SRL;
        narrow = 1'b1;
      end
      vx_shift_pkg::VNCLIP: begin
        op     = vx_shift_pkg::SHIFT_SRA;
        narrow = 1'b1;
      end
      default: begin
        known = 1'b0;
      end
    endcase
  end

  // no 8-bit source for narrowing clips
  assign accept = in_valid & known & ~(narrow & (uop.eew == vx_shift_pkg::EEW8));

  always_comb begin
    raw_amount           = '0;
    ops_next.ctx.funct6    = uop.funct6;
    ops_next.ctx.eew       = uop.eew;
    ops_next.ctx.vxrm      = uop.vxrm;
    ops_next.ctx.op        = op;
    ops_next.ctx.uop_index = uop.uop_index;
    ops_next.vs2           = uop.vs2;
    for (int k = 0; k < vx_shift_pkg::VLENB; k++) begin
      // element starting at byte k has its lsb at bit 8k of vs1
      if (uop.funct3 == vx_shift_pkg::OPIVV) begin
        raw_amount = uop.vs1[k*vx_shift_pkg::BYTE_WIDTH +: vx_shift_pkg::SHAMT_WIDTH];
      end else begin
        raw_amount = uop.rs1[vx_shift_pkg::SHAMT_WIDTH-1:0];
      end
      case (uop.eew)
        vx_shift_pkg::EEW8:  ops_next.amount[k] = {2'b00, raw_amount[2:0]};
        vx_shift_pkg::EEW16: ops_next.amount[k] = (k % 2 == 0) ? {1'b0, raw_amount[3:0]} : '0;
        vx_shift_pkg::EEW32: ops_next.amount[k] = (k % 4 == 0) ? raw_amount : '0;
        default:             ops_next.amount[k] = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      op_valid <= 1'b0;
    end else begin
      op_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ops <= ops_next;
    end
  end

endmodule

// ==== rtl/shift_round_stage.sv ====
`timescale 1ns/1ps

module shift_round_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          op_valid,
  input  vx_shift_pkg::operand_bundle_t ops,
  output logic                          lane_valid,
  output vx_shift_pkg::lane_bundle_t    lanes
);

  vx_shift_pkg::lane_bundle_t lanes_next;

  assign lanes_next.ctx = ops.ctx;

  // every width group is computed, stage 3 picks by eew
  for (genvar j = 0; j < vx_shift_pkg::VLENB; j++) begin : g_byte
    vx_shift_lane #(
      .elem_t(logic [vx_shift_pkg::BYTE_WIDTH-1:0])
    ) u_lane (
      .op      (ops.ctx.op),
      .vxrm    (ops.ctx.vxrm),
      .elem    (ops.vs2[j*vx_shift_pkg::BYTE_WIDTH +: vx_shift_pkg::BYTE_WIDTH]),
      .amount  (ops.amount[j]),
      .shifted (lanes_next.shifted8[j]),
      .rounded (lanes_next.rounded8[j]),
      .cout    (lanes_next.cout8[j])
    );
  end

  for (genvar j = 0; j < vx_shift_pkg::NUM_HWORDS; j++) begin : g_hword
    vx_shift_lane #(
      .elem_t(logic [vx_shift_pkg::HWORD_WIDTH-1:0])
    ) u_lane (
      .op      (ops.ctx.op),
      .vxrm    (ops.ctx.vxrm),
      .elem    (ops.vs2[j*vx_shift_pkg::HWORD_WIDTH +: vx_shift_pkg::HWORD_WIDTH]),
      .amount  (ops.amount[j*vx_shift_pkg::HWORD_WIDTH/vx_shift_pkg::BYTE_WIDTH]),
      .shifted (lanes_next.shifted16[j]),
      .rounded (lanes_next.rounded16[j]),
      .cout    (lanes_next.cout16[j])
    );
  end

  for (genvar j = 0; j < vx_shift_pkg::NUM_WORDS; j++) begin : g_word
    vx_shift_lane #(
      .elem_t(logic [vx_shift_pkg::WORD_WIDTH-1:0])
    ) u_lane (
      .op      (ops.ctx.op),
      .vxrm    (ops.ctx.vxrm),
      .elem    (ops.vs2[j*vx_shift_pkg::WORD_WIDTH +: vx_shift_pkg::WORD_WIDTH]),
      .amount  (ops.amount[j*vx_shift_pkg::WORD_WIDTH/vx_shift_pkg::BYTE_WIDTH]),
      .shifted (lanes_next.shifted32[j]),
      .rounded (lanes_next.rounded32[j]),
      .cout    (lanes_next.cout32[j])
    );
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= op_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      lanes <= lanes_next;
    end
  end

endmodule

// ==== rtl/vx_shift_lane.sv ====
`timescale 1ns/1ps

module vx_shift_lane #(
  parameter type elem_t = logic [vx_shift_pkg::BYTE_WIDTH-1:0]
) (
  input  vx_shift_pkg::shift_op_e          op,
  input  vx_shift_pkg::vxrm_e              vxrm,
  input  elem_t                            elem,
  input  logic [vx_shift_pkg::SHAMT_WIDTH-1:0] amount,
  output elem_t                            shifted,
  output elem_t                            rounded,
  output logic                             cout
);

  logic [2*$bits(elem_t)-1:0] ext;
  logic [2*$bits(elem_t)-1:0] wide;
  elem_t                      round_bits;
  logic                       incr;
  logic                       top;

  // low half catches the bits shifted out
  assign ext = {elem, {$bits(elem_t){1'b0}}};

  always_comb begin
    case (op)
      vx_shift_pkg::SHIFT_SLL: wide = ext << amount;
      vx_shift_pkg::SHIFT_SRA: wide = $signed(ext) >>> amount;
      default:                 wide = ext >> amount;
    endcase
  end

  assign shifted    = wide[$bits(elem_t) +: $bits(elem_t)];
  assign round_bits = wide[$bits(elem_t)-1:0];

  always_comb begin
    case (vxrm)
      vx_shift_pkg::RNU: incr = round_bits[$bits(elem_t)-1];
      vx_shift_pkg::RNE: incr = round_bits[$bits(elem_t)-1] &
                                ((|round_bits[$bits(elem_t)-2:0]) | shifted[0]);
      vx_shift_pkg::ROD: incr = ~shifted[0] & (|round_bits);
      default:           incr = 1'b0;
    endcase
  end

  assign top = (op == vx_shift_pkg::SHIFT_SRA) & shifted[$bits(elem_t)-1];
  assign {cout, rounded} = {top, shifted} + {{$bits(elem_t){1'b0}}, incr};

endmodule

// ==== rtl/vx_shift_pkg.sv ====
package vx_shift_pkg;

  localparam int VLEN        = 64;
  localparam int XLEN        = 32;
  localparam int VLENB       = VLEN / 8;
  localparam int BYTE_WIDTH  = 8;
  localparam int HWORD_WIDTH = 16;
  localparam int WORD_WIDTH  = 32;
  localparam int NUM_HWORDS  = VLEN / HWORD_WIDTH;
  localparam int NUM_WORDS   = VLEN / WORD_WIDTH;
  localparam int SHAMT_WIDTH = 5;

  // OPIVV/OPIVX/OPIVI funct6 of the shift group
  typedef enum logic [5:0] {
    VSLL    = 6'b100101,
    VSRL    = 6'b101000,
    VSRA    = 6'b101001,
    VSSRL   = 6'b101010,
    VSSRA   = 6'b101011,
    VNCLIPU = 6'b101110,
    VNCLIP  = 6'b101111
  } shift_funct6_e;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } operand_src_e;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  typedef enum logic [1:0] {
    RNU = 2'd0,
    RNE = 2'd1,
    RDN = 2'd2,
    ROD = 2'd3
  } vxrm_e;

  typedef enum logic [1:0] {
    SHIFT_SLL = 2'd0,
    SHIFT_SRL = 2'd1,
    SHIFT_SRA = 2'd2
  } shift_op_e;

  typedef struct packed {
    shift_funct6_e   funct6;
    operand_src_e    funct3;
    vxrm_e           vxrm;
    eew_e            eew;
    logic [VLEN-1:0] vs1;
    logic [VLEN-1:0] vs2;
    logic [XLEN-1:0] rs1;
    logic            uop_index;    // bit 0 only, picks the narrowing half
  } shift_uop_t;

  typedef struct packed {
    shift_funct6_e funct6;
    eew_e          eew;
    vxrm_e         vxrm;
    shift_op_e     op;
    logic          uop_index;
  } shift_ctx_t;

  typedef struct packed {
    shift_ctx_t                        ctx;
    logic [VLEN-1:0]                   vs2;
    logic [VLENB-1:0][SHAMT_WIDTH-1:0] amount;
  } operand_bundle_t;

  typedef struct packed {
    shift_ctx_t                            ctx;
    logic [VLENB-1:0][BYTE_WIDTH-1:0]      shifted8;
    logic [NUM_HWORDS-1:0][HWORD_WIDTH-1:0] shifted16;
    logic [NUM_WORDS-1:0][WORD_WIDTH-1:0]  shifted32;
    logic [VLENB-1:0][BYTE_WIDTH-1:0]      rounded8;
    logic [NUM_HWORDS-1:0][HWORD_WIDTH-1:0] rounded16;
    logic [NUM_WORDS-1:0][WORD_WIDTH-1:0]  rounded32;
    logic [VLENB-1:0]                      cout8;
    logic [NUM_HWORDS-1:0]                 cout16;
    logic [NUM_WORDS-1:0]                  cout32;
  } lane_bundle_t;

  typedef struct packed {
    logic [VLEN-1:0] data;
    logic            vxsat;
  } shift_result_t;

endpackage

// ==== rtl/vx_shift_unit.sv ====
`timescale 1ns/1ps

module vx_shift_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  input  vx_shift_pkg::shift_uop_t    uop,
  output logic                        result_valid,
  output vx_shift_pkg::shift_result_t result
);

  logic                          op_valid;
  vx_shift_pkg::operand_bundle_t ops;
  logic                          lane_valid;
  vx_shift_pkg::lane_bundle_t    lanes;

  // decode and amount extraction
  shift_operand_stage u_operand (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .uop      (uop),
    .op_valid (op_valid),
    .ops      (ops)
  );

  shift_round_stage u_round (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .ops        (ops),
    .lane_valid (lane_valid),
    .lanes      (lanes)
  );

  // result select, clip and vxsat
  narrow_clip_stage u_clip (
    .clk          (clk),
    .rst          (rst),
    .lane_valid   (lane_valid),
    .lanes        (lanes),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -f tb.f --top-module vx_shift_unit_tb -o vx_shift_sim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/vx_shift_sim > sim.log 2>&1
grep -q "Test failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation passed"

// ==== tb.f ====
+incdir+bench
rtl/vx_shift_pkg.sv
rtl/vx_shift_lane.sv
rtl/shift_operand_stage.sv
rtl/shift_round_stage.sv
rtl/narrow_clip_stage.sv
rtl/vx_shift_unit.sv
bench/vx_shift_unit_tb.sv
